// ==== src/memPkg.sv ====
/*
 * data bus and RAM types
 * shared by the MEM stage, the data RAM and the WB stage
 */

package memPkg;

    // one 32-bit data word
    typedef logic [31:0] word;

    // one enable per byte lane, bit 0 is the low byte
    typedef logic [3:0] byteEn;

    // request from MEM to the data RAM, valid in the same cycle
    typedef struct packed {
        logic  en;     // access this cycle
        logic  we;     // store when set, load otherwise
        word   addr;   // byte address, already masked to RAM size
        byteEn be;     // lanes to write
        word   wdata;  // store data, replicated into every lane
    } dataReq;

endpackage

// ==== src/pipePkg.sv ====
/*
 * pipeline types for the MEM, MEM2 and WB stages
 * memory op and write-back select codes, and the stage-to-stage bundles
 */

package pipePkg;

    // register file index
    typedef logic [4:0] regAddr;

    typedef enum logic [3:0] {
        memNone,
        memLb,
        memLbu,
        memLh,
        memLhu,
        memLw,
        memSb,
        memSh,
        memSw
    } memOp;

    // source of the register write value
    typedef enum logic [1:0] {
        wbPcPlus8,  // link instructions
        wbAlu,
        wbOutB,     // move-type writes
        wbMem       // load data, only known in WB
    } wbSel;

    typedef enum logic [1:0] {
        excNone,
        excAdEL,    // load address error
        excAdES     // store address error
    } excCode;

    // executed instruction entering MEM
    typedef struct packed {
        logic        valid;
        memPkg::word pc;
        memPkg::word aluOut;   // also the memory address
        memPkg::word outB;     // store operand
        regAddr      dst;
        logic        regWr;
        memOp        op;
        wbSel        sel;
    } exMemBus;

    // MEM to MEM2, adds the address check result
    typedef struct packed {
        logic        valid;
        memPkg::word pc;
        memPkg::word aluOut;
        memPkg::word outB;
        regAddr      dst;
        logic        regWr;    // already cleared on an address error
        memOp        op;
        wbSel        sel;
        excCode      exc;
    } memMem2Bus;

    // registered MEM2 copy headed for WB
    typedef struct packed {
        logic        valid;
        memPkg::word pc;
        memPkg::word aluOut;
        memPkg::word outB;
        regAddr      dst;
        logic        regWr;
        memOp        op;
        wbSel        sel;
        excCode      exc;
    } mem2WbBus;

endpackage

// ==== src/memAccess.sv ====
/*
 * MEM stage
 * registers the executed instruction, builds the RAM request with byte lanes
 * and flags misaligned halfword and word accesses
 */
`timescale 1ns/10ps

module memAccess #(
    parameter int ramAddrBits = 8
) (
    input  logic               clk,
    input  logic               arstN,
    input  pipePkg::exMemBus   exIn,
    output memPkg::dataReq     req,
    output pipePkg::memMem2Bus toMem2
);

    pipePkg::exMemBus memReg;
    memPkg::word      maskedAddr;
    memPkg::byteEn    laneEn;
    memPkg::word      laneData;
    logic             isLoad;
    logic             isStore;
    logic             misaligned;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memReg <= '0;
        end else begin
            memReg <= exIn;
        end
    end

    // drop address bits beyond the RAM
    assign maskedAddr = {{(30 - ramAddrBits){1'b0}}, memReg.aluOut[ramAddrBits+1:0]};

    assign isLoad  = memReg.op inside {pipePkg::memLb, pipePkg::memLbu, pipePkg::memLh,
                                       pipePkg::memLhu, pipePkg::memLw};
    assign isStore = memReg.op inside {pipePkg::memSb, pipePkg::memSh, pipePkg::memSw};

    // lane enables and store data placement per access size
    always_comb begin
        laneEn     = 4'b0000;
        laneData   = memReg.outB;
        misaligned = 1'b0;
        case (memReg.op)
            pipePkg::memLb, pipePkg::memLbu, pipePkg::memSb: begin
                laneEn   = 4'b0001 << memReg.aluOut[1:0];
                laneData = {4{memReg.outB[7:0]}};
            end
            pipePkg::memLh, pipePkg::memLhu, pipePkg::memSh: begin
                laneEn     = memReg.aluOut[1] ? 4'b1100 : 4'b0011;
                laneData   = {2{memReg.outB[15:0]}};
                misaligned = memReg.aluOut[0];        // halfword needs bit 0 clear
            end
            pipePkg::memLw, pipePkg::memSw: begin
                laneEn     = 4'b1111;
                misaligned = |memReg.aluOut[1:0];
            end
            default: begin
                laneEn = 4'b0000;                     // no memory access
            end
        endcase
    end

    // a faulting access never reaches the RAM
    always_comb begin
        req.en    = memReg.valid && (isLoad || isStore) && !misaligned;
        req.we    = isStore;
        req.addr  = maskedAddr;
        req.be    = laneEn;
        req.wdata = laneData;
    end

    always_comb begin
        toMem2.valid  = memReg.valid;
        toMem2.pc     = memReg.pc;
        toMem2.aluOut = memReg.aluOut;
        toMem2.outB   = memReg.outB;
        toMem2.dst    = memReg.dst;
        toMem2.regWr  = memReg.regWr && !misaligned;  // no write on address error
        toMem2.op     = memReg.op;
        toMem2.sel    = memReg.sel;
        if (!misaligned) begin
            toMem2.exc = pipePkg::excNone;
        end else if (isStore) begin
            toMem2.exc = pipePkg::excAdES;
        end else begin
            toMem2.exc = pipePkg::excAdEL;
        end
    end

endmodule

// ==== src/dataRam.sv ====
/*
 * data RAM, one word wide
 * byte-enable write and registered read, both on the rising edge
 */
`timescale 1ns/10ps

module dataRam #(
    parameter int ramAddrBits = 8
) (
    input  logic           clk,
    input  memPkg::dataReq req,
    output memPkg::word    rdata
);

    localparam int ramDepth = 1 << ramAddrBits;

    memPkg::word              mem [ramDepth];
    logic [ramAddrBits-1:0]   wordIdx;

    assign wordIdx = req.addr[ramAddrBits+1:2];   // word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (req.en && req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    mem[wordIdx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // read word lands in time for the MEM2 cycle
    always_ff @(posedge clk) begin
        if (req.en && !req.we) begin
            rdata <= mem[wordIdx];
        end
    end

endmodule

// ==== src/mem2Stage.sv ====
/*
 * MEM2 pipeline register
 * flushable copy of the MEM bundle, plus the forwarding result mux
 */
`timescale 1ns/10ps

module mem2Stage (
    input  logic               clk,
    input  logic               arstN,
    input  logic               mem2Flush,
    input  pipePkg::memMem2Bus fromMem,
    output pipePkg::mem2WbBus  toWb,
    output memPkg::word        mem2Result,
    output pipePkg::regAddr    mem2Dst,
    output logic               mem2RegWr
);

    pipePkg::mem2WbBus m2Reg;

    // a flush loads a bubble, the RAM side is not undone
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            m2Reg <= '0;
        end else if (mem2Flush) begin
            m2Reg <= '0;
        end else begin
            m2Reg <= pipePkg::mem2WbBus'(fromMem);
        end
    end

    assign toWb = m2Reg;

    // forwarding value, load data is not available yet
    always_comb begin
        case (m2Reg.sel)
            pipePkg::wbPcPlus8: begin
                mem2Result = m2Reg.pc + 32'd8;        // link address
            end
            pipePkg::wbAlu: begin
                mem2Result = m2Reg.aluOut;
            end
            pipePkg::wbOutB: begin
                mem2Result = m2Reg.outB;
            end
            default: begin
                mem2Result = m2Reg.aluOut;            // load, consumer must wait for WB
            end
        endcase
    end

    assign mem2Dst   = m2Reg.dst;
    assign mem2RegWr = m2Reg.valid && m2Reg.regWr;

endmodule

// ==== src/writeBack.sv ====
/*
 * WB stage
 * extracts and extends load data, selects the register write value
 * and reports address errors
 */
`timescale 1ns/10ps

module writeBack (
    input  logic              clk,
    input  logic              arstN,
    input  pipePkg::mem2WbBus fromMem2,
    input  memPkg::word       rdata,
    output logic              rfWe,
    output pipePkg::regAddr   rfAddr,
    output memPkg::word       rfData,
    output logic              excValid,
    output pipePkg::excCode   excCode,
    output memPkg::word       excPc
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    memPkg::word loadData;
    memPkg::word wrData;

    // lane picked by the low address bits
    assign loadByte = rdata[{fromMem2.aluOut[1:0], 3'b000} +: 8];
    assign loadHalf = fromMem2.aluOut[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (fromMem2.op)
            pipePkg::memLb:  loadData = {{24{loadByte[7]}}, loadByte};
            pipePkg::memLbu: loadData = {24'h000000, loadByte};
            pipePkg::memLh:  loadData = {{16{loadHalf[15]}}, loadHalf};
            pipePkg::memLhu: loadData = {16'h0000, loadHalf};
            default:         loadData = rdata;        // full word
        endcase
    end

    always_comb begin
        case (fromMem2.sel)
            pipePkg::wbPcPlus8: wrData = fromMem2.pc + 32'd8;
            pipePkg::wbAlu:     wrData = fromMem2.aluOut;
            pipePkg::wbOutB:    wrData = fromMem2.outB;
            default:            wrData = loadData;
        endcase
    end

    // strobes, r0 is never written
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rfWe     <= 1'b0;
            excValid <= 1'b0;
        end else begin
            rfWe     <= fromMem2.valid && fromMem2.regWr && (fromMem2.dst != 5'd0);
            excValid <= fromMem2.valid && (fromMem2.exc != pipePkg::excNone);
        end
    end

    always_ff @(posedge clk) begin
        rfAddr  <= fromMem2.dst;
        rfData  <= wrData;
        excCode <= fromMem2.exc;
        excPc   <= fromMem2.pc;   // faulting instruction
    end

endmodule

// ==== src/memBackEnd.sv ====
/*
 * pipeline back end
 * MEM, MEM2 and WB stages around a single-cycle data RAM
 */
`timescale 1ns/10ps

module memBackEnd #(
    parameter int ramAddrBits = 8
) (
    input  logic             clk,
    input  logic             arstN,
    input  pipePkg::exMemBus exIn,
    input  logic             mem2Flush,
    output memPkg::word      mem2Result,
    output pipePkg::regAddr  mem2Dst,
    output logic             mem2RegWr,
    output logic             rfWe,
    output pipePkg::regAddr  rfAddr,
    output memPkg::word      rfData,
    output logic             excValid,
    output pipePkg::excCode  excCode,
    output memPkg::word      excPc
);

    memPkg::dataReq     ramReq;
    memPkg::word        ramData;    // belongs to the instruction in MEM2
    pipePkg::memMem2Bus memToMem2;
    pipePkg::mem2WbBus  mem2ToWb;

    memAccess #(
        .ramAddrBits (ramAddrBits)
    ) memAccess_i (
        .clk    (clk),
        .arstN  (arstN),
        .exIn   (exIn),
        .req    (ramReq),
        .toMem2 (memToMem2)
    );

    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) dataRam_i (
        .clk   (clk),
        .req   (ramReq),
        .rdata (ramData)
    );

    mem2Stage mem2Stage_i (
        .clk        (clk),
        .arstN      (arstN),
        .mem2Flush  (mem2Flush),
        .fromMem    (memToMem2),
        .toWb       (mem2ToWb),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegWr  (mem2RegWr)
    );

    writeBack writeBack_i (
        .clk      (clk),
        .arstN    (arstN),
        .fromMem2 (mem2ToWb),
        .rdata    (ramData),
        .rfWe     (rfWe),
        .rfAddr   (rfAddr),
        .rfData   (rfData),
        .excValid (excValid),
        .excCode  (excCode),
        .excPc    (excPc)
    );

endmodule

// ==== tb/memBackEndTb.sv ====
/*
 * testbench for the pipeline back end
 * LFSR driven instructions against a reference model of the stages and RAM
 */
`timescale 1ns/10ps

module memBackEndTb;

    localparam int ramBits     = 8;
    localparam int clkPeriod   = 20;
    localparam int resetCycles = 8;
    localparam int numRandom   = 300;
    localparam int numTests    = 400;   // upper bound on issued slots

    typedef struct packed {
        logic            fwdOn;
        memPkg::word     fwdRes;
        pipePkg::regAddr fwdDst;
        logic            we;
        pipePkg::regAddr wAddr;
        memPkg::word     wData;
        logic            exc;
        pipePkg::excCode code;
        memPkg::word     ePc;
    } expOut;

    logic             clk;
    logic             arstN;
    pipePkg::exMemBus exIn;
    logic             mem2Flush;
    memPkg::word      mem2Result;
    pipePkg::regAddr  mem2Dst;
    logic             mem2RegWr;
    logic             rfWe;
    pipePkg::regAddr  rfAddr;
    memPkg::word      rfData;
    logic             excValid;
    pipePkg::excCode  excCode;
    memPkg::word      excPc;

    memPkg::word ramModel [1 << ramBits];
    expOut       fwdArr [numTests + 40];
    expOut       wbArr [numTests + 40];
    int          cyc;
    int          fwdErr;
    int          regErr;
    int          excErr;
    logic        done;
    logic [31:0] lfsrState;
    memPkg::word pcNext;

    memBackEnd #(
        .ramAddrBits (ramBits)
    ) dut_i (
        .clk        (clk),
        .arstN      (arstN),
        .exIn       (exIn),
        .mem2Flush  (mem2Flush),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegWr  (mem2RegWr),
        .rfWe       (rfWe),
        .rfAddr     (rfAddr),
        .rfData     (rfData),
        .excValid   (excValid),
        .excCode    (excCode),
        .excPc      (excPc)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (arstN) cyc <= cyc + 1;    // slot counter shared by driver and checker
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrStep();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) lfsrState = lfsrState ^ 32'h8020_0003;
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrStep()};
        end
        return r;
    endfunction

    // expected MEM2 and WB outcome plus the RAM model update
    function automatic expOut predictOutcome(input pipePkg::exMemBus x);
        expOut       e;
        logic        isLd;
        logic        isSt;
        logic        mis;
        logic [7:0]  idx;
        logic [7:0]  b;
        logic [15:0] h;
        memPkg::word w;
        memPkg::word ld;
        e = '0;
        if (!x.valid) return e;
        isLd = x.op == pipePkg::memLb || x.op == pipePkg::memLbu || x.op == pipePkg::memLh
            || x.op == pipePkg::memLhu || x.op == pipePkg::memLw;
        isSt = x.op == pipePkg::memSb || x.op == pipePkg::memSh || x.op == pipePkg::memSw;
        case (x.op)
            pipePkg::memLh, pipePkg::memLhu, pipePkg::memSh: mis = x.aluOut[0];
            pipePkg::memLw, pipePkg::memSw:                  mis = x.aluOut[1:0] != 2'b00;
            default:                                         mis = 1'b0;
        endcase
        idx = x.aluOut[9:2];
        w   = ramModel[idx];
        b   = w[8*x.aluOut[1:0] +: 8];
        h   = w[16*x.aluOut[1] +: 16];
        case (x.op)
            pipePkg::memLb:  ld = {{24{b[7]}}, b};
            pipePkg::memLbu: ld = {24'h000000, b};
            pipePkg::memLh:  ld = {{16{h[15]}}, h};
            pipePkg::memLhu: ld = {16'h0000, h};
            default:         ld = w;
        endcase
        if (isSt && !mis) begin
            case (x.op)
                pipePkg::memSb: ramModel[idx][8*x.aluOut[1:0] +: 8] = x.outB[7:0];
                pipePkg::memSh: ramModel[idx][16*x.aluOut[1] +: 16] = x.outB[15:0];
                default:        ramModel[idx] = x.outB;
            endcase
        end
        e.fwdOn  = x.regWr && !mis;
        e.fwdDst = x.dst;
        case (x.sel)
            pipePkg::wbPcPlus8: e.fwdRes = x.pc + 32'd8;
            pipePkg::wbOutB:    e.fwdRes = x.outB;
            default:            e.fwdRes = x.aluOut;   // loads forward the address
        endcase
        e.we    = x.regWr && !mis && x.dst != 5'd0;
        e.wAddr = x.dst;
        e.wData = (x.sel == pipePkg::wbMem && isLd) ? ld : e.fwdRes;
        e.exc   = mis;
        e.code  = isSt ? pipePkg::excAdES : pipePkg::excAdEL;
        e.ePc   = x.pc;
        return e;
    endfunction

    function automatic pipePkg::exMemBus mkInstr(input pipePkg::memOp op,
            input pipePkg::wbSel sel, input memPkg::word addr, input memPkg::word data,
            input pipePkg::regAddr dst, input logic regWr);
        pipePkg::exMemBus x;
        x.valid  = 1'b1;
        x.pc     = pcNext;
        x.aluOut = addr;
        x.outB   = data;
        x.dst    = dst;
        x.regWr  = regWr;
        x.op     = op;
        x.sel    = sel;
        pcNext   = pcNext + 32'd4;
        return x;
    endfunction

    function automatic pipePkg::exMemBus randInstr();
        pipePkg::memOp op;
        pipePkg::wbSel sel;
        logic [31:0]   idx;
        logic [31:0]   off;
        logic          keepRaw;
        logic          wr;
        op      = pipePkg::memOp'(4'(randBits(4) % 9));
        idx     = randBits(4);
        off     = randBits(2);
        keepRaw = randBits(3) == 32'd0;   // about one in eight misaligned
        if (!keepRaw) begin
            if (op inside {pipePkg::memLh, pipePkg::memLhu, pipePkg::memSh}) off = off & 32'd2;
            if (op inside {pipePkg::memLw, pipePkg::memSw}) off = 32'd0;
        end
        if (op inside {pipePkg::memSb, pipePkg::memSh, pipePkg::memSw}) begin
            sel = pipePkg::wbAlu;
            wr  = 1'b0;
        end else if (op == pipePkg::memNone) begin
            sel = pipePkg::wbSel'(2'(randBits(2)));
            if (sel == pipePkg::wbMem) sel = pipePkg::wbAlu;
            wr  = randBits(3) != 32'd0;
        end else begin
            sel = pipePkg::wbMem;
            wr  = 1'b1;
        end
        return mkInstr(op, sel, idx * 4 + off, randBits(32), 5'(randBits(5)), wr);
    endfunction

    // one slot where a flush kills the instruction of the slot before
    task automatic issue(input pipePkg::exMemBus x, input logic flushPrev);
        expOut e;
        @(negedge clk);
        exIn      = x;
        mem2Flush = flushPrev;
        if (flushPrev) begin
            fwdArr[cyc+1] = '0;
            wbArr[cyc+2]  = '0;
        end
        e = predictOutcome(x);
        fwdArr[cyc+2] = e;
        wbArr[cyc+3]  = e;
    endtask

    task automatic checkForward(input memPkg::word gotRes, input pipePkg::regAddr gotDst,
            input memPkg::word expRes, input pipePkg::regAddr expDst);
        if (gotRes !== expRes || gotDst !== expDst) begin
            fwdErr++;
            $display("mismatch at %0t: forward r%0d=%h, expected r%0d=%h",
                     $time, gotDst, gotRes, expDst, expRes);
        end
    endtask

    task automatic checkRegWrite(input pipePkg::regAddr gotA, input memPkg::word gotD,
            input pipePkg::regAddr expA, input memPkg::word expD);
        if (gotA !== expA || gotD !== expD) begin
            regErr++;
            $display("mismatch at %0t: write r%0d=%h, expected r%0d=%h",
                     $time, gotA, gotD, expA, expD);
        end
    endtask

    task automatic checkExc(input pipePkg::excCode gotC, input memPkg::word gotPc,
            input pipePkg::excCode expC, input memPkg::word expPc);
        if (gotC !== expC || gotPc !== expPc) begin
            excErr++;
            $display("mismatch at %0t: exception %s pc %h, expected %s pc %h",
                     $time, gotC.name(), gotPc, expC.name(), expPc);
        end
    endtask

    always @(negedge clk) begin : compareOutputs
        expOut f;
        expOut w;
        if (!done) begin
            f = fwdArr[cyc];
            w = wbArr[cyc];
            if (mem2RegWr !== f.fwdOn) begin
                fwdErr++;
                $display("mismatch at %0t: mem2RegWr %b, expected %b", $time, mem2RegWr, f.fwdOn);
            end else if (f.fwdOn) begin
                checkForward(mem2Result, mem2Dst, f.fwdRes, f.fwdDst);
            end
            if (rfWe !== w.we) begin
                regErr++;
                $display("mismatch at %0t: rfWe %b, expected %b", $time, rfWe, w.we);
            end else if (w.we) begin
                checkRegWrite(rfAddr, rfData, w.wAddr, w.wData);
            end
            if (excValid !== w.exc) begin
                excErr++;
                $display("mismatch at %0t: excValid %b, expected %b", $time, excValid, w.exc);
            end else if (w.exc) begin
                checkExc(excCode, excPc, w.code, w.ePc);
            end
        end
    end

    initial begin
        #((numTests + 20 + resetCycles) * clkPeriod);
        $display("timeout: the run did not finish in the expected time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        lfsrState = 32'd68722;
        pcNext    = 32'h0040_0000;
        cyc       = 0;
        fwdErr    = 0;
        regErr    = 0;
        excErr    = 0;
        done      = 1'b0;
        exIn      = '0;
        mem2Flush = 1'b0;
        arstN     = 1'b0;
        for (int i = 0; i < numTests + 40; i++) begin
            fwdArr[i] = '0;
            wbArr[i]  = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        // fill the address window so every load reads known data
        for (int i = 0; i < 16; i++) begin
            issue(mkInstr(pipePkg::memSw, pipePkg::wbAlu, 32'(i * 4), randBits(32), 5'd0, 1'b0),
                  1'b0);
        end
        // loads of every width and offset
        issue(mkInstr(pipePkg::memSw, pipePkg::wbAlu, 32'h20, 32'h8A7F_F081, 5'd0, 1'b0), 1'b0);
        for (int i = 0; i < 4; i++) begin
            issue(mkInstr(pipePkg::memLb, pipePkg::wbMem, 32'h20 + i, '0, 5'd3, 1'b1), 1'b0);
            issue(mkInstr(pipePkg::memLbu, pipePkg::wbMem, 32'h20 + i, '0, 5'd4, 1'b1), 1'b0);
        end
        for (int i = 0; i < 4; i += 2) begin
            issue(mkInstr(pipePkg::memLh, pipePkg::wbMem, 32'h20 + i, '0, 5'd5, 1'b1), 1'b0);
            issue(mkInstr(pipePkg::memLhu, pipePkg::wbMem, 32'h20 + i, '0, 5'd6, 1'b1), 1'b0);
        end
        issue(mkInstr(pipePkg::memSb, pipePkg::wbAlu, 32'h21, 32'h0000_00C3, 5'd0, 1'b0), 1'b0);
        issue(mkInstr(pipePkg::memSh, pipePkg::wbAlu, 32'h22, 32'h0000_9E55, 5'd0, 1'b0), 1'b0);
        issue(mkInstr(pipePkg::memLw, pipePkg::wbMem, 32'h20, '0, 5'd7, 1'b1), 1'b0);
        // non-memory writes where r0 gives none
        issue(mkInstr(pipePkg::memNone, pipePkg::wbPcPlus8, 32'h1234, 32'h55, 5'd8, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memNone, pipePkg::wbAlu, 32'h1234, 32'h55, 5'd9, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memNone, pipePkg::wbOutB, 32'h1234, 32'h55, 5'd10, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memNone, pipePkg::wbAlu, 32'h1234, 32'h55, 5'd0, 1'b1), 1'b0);
        // address errors whose faulting stores leave the word alone
        issue(mkInstr(pipePkg::memSw, pipePkg::wbAlu, 32'h30, 32'h1122_3344, 5'd0, 1'b0), 1'b0);
        issue(mkInstr(pipePkg::memLh, pipePkg::wbMem, 32'h31, '0, 5'd11, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memLw, pipePkg::wbMem, 32'h32, '0, 5'd12, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memSh, pipePkg::wbAlu, 32'h33, 32'hFFFF, 5'd0, 1'b0), 1'b0);
        issue(mkInstr(pipePkg::memSw, pipePkg::wbAlu, 32'h31, 32'hFFFF_FFFF, 5'd0, 1'b0), 1'b0);
        issue(mkInstr(pipePkg::memLw, pipePkg::wbMem, 32'h30, '0, 5'd13, 1'b1), 1'b0);
        // flushed store still commits while a flushed ALU op vanishes
        issue(mkInstr(pipePkg::memSw, pipePkg::wbAlu, 32'h34, 32'hDEAD_BEEF, 5'd0, 1'b0), 1'b0);
        issue('0, 1'b1);
        issue(mkInstr(pipePkg::memLw, pipePkg::wbMem, 32'h34, '0, 5'd14, 1'b1), 1'b0);
        issue(mkInstr(pipePkg::memNone, pipePkg::wbAlu, 32'h77, '0, 5'd15, 1'b1), 1'b0);
        issue('0, 1'b1);
        // a flushed address error raises no exception
        issue(mkInstr(pipePkg::memLw, pipePkg::wbMem, 32'h36, '0, 5'd16, 1'b1), 1'b0);
        issue('0, 1'b1);
        // back to back random traffic
        for (int i = 0; i < numRandom; i++) begin
            issue(randInstr(), randBits(4) == 32'd0);
        end
        repeat (5) issue('0, 1'b0);
        @(posedge clk);
        done = 1'b1;
        $display("errors: forward %0d, register write %0d, exception %0d",
                 fwdErr, regErr, excErr);
        if (fwdErr + regErr + excErr == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/memPkg.sv
src/pipePkg.sv
src/memAccess.sv
src/dataRam.sv
src/mem2Stage.sv
src/writeBack.sv
src/memBackEnd.sv
tb/memBackEndTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module memBackEndTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    exit 1
fi
exit 0
